//--- Makefile
SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= tb_sdram_controller
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	set -o pipefail; $(SIM) $(SIM_ARGS) | tee $(LOG)
	! grep -q "Checks failed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/access_sequencer.sv
module access_sequencer
    import sdram_pkg::*;
    import ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  user_addr_t           user_addr,
    input  logic                 rw,
    input  word_t                data_in,
    input  logic                 in_valid,
    input  logic                 grant,
    input  logic                 bus_free,
    input  logic [NUM_BANKS-1:0] row_open,
    input  row_t [NUM_BANKS-1:0] open_row,
    input  word_t                sdram_dqi,
    output logic                 busy,
    output word_t                data_out,
    output logic                 out_valid,
    output logic                 req,
    output logic                 lock,
    output sdram_cmd_t           cmd,
    output bank_t                bank,
    output pin_addr_t            addr,
    output word_t                wdata
);

    localparam int RD_W = $clog2(CAS_LATENCY + 1);

    seq_state_t  state;
    seq_state_t  choice;
    logic        q_rw;
    user_addr_t  q_addr;
    word_t       q_data;
    word_t       rd_word;
    logic [RD_W-1:0] rd_cnt;
    row_t        q_row;
    bank_t       q_bank;
    col_t        q_col;
    logic        bank_open;
    logic        row_hit;

    assign q_row  = q_addr[ROW_LSB +: $bits(row_t)];
    assign q_bank = q_addr[BANK_LSB +: $bits(bank_t)];
    assign q_col  = q_addr[COL_LSB +: $bits(col_t)];

    // next step for the queued request, from the current table
    assign bank_open = row_open[q_bank];
    assign row_hit   = bank_open && (open_row[q_bank] == q_row);
    assign choice    = row_hit ? ISSUE : (bank_open ? PRECHARGE : ACTIVATE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            busy      <= 1'b0;
            out_valid <= 1'b0;
            lock      <= 1'b0;
            rd_cnt    <= '0;
        end else begin
            out_valid <= 1'b0;
            if (!busy && in_valid) busy <= 1'b1;
            case (state)
                IDLE: if (busy) state <= choice;
                // a refresh may close the bank before we get the bus,
                // so re-decide every cycle until granted
                PRECHARGE, ACTIVATE: begin
                    if (grant) begin
                        lock  <= 1'b1;
                        state <= (state == PRECHARGE) ? ACTIVATE : ISSUE;
                    end else begin
                        state <= choice;
                    end
                end
                ISSUE: begin
                    if (grant) begin
                        lock   <= 1'b0;
                        rd_cnt <= RD_W'(CAS_LATENCY);
                        state  <= q_rw ? WRITE_WAIT : READ_WAIT;
                    end else begin
                        state <= choice;
                    end
                end
                READ_WAIT: begin
                    rd_cnt <= rd_cnt - 1'b1;
                    if (rd_cnt == '0) begin
                        out_valid <= 1'b1;
                        busy      <= 1'b0;
                        state     <= IDLE;
                    end
                end
                WRITE_WAIT: begin
                    if (bus_free) begin
                        busy  <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && in_valid) begin
            q_rw   <= rw;
            q_addr <= user_addr;
            q_data <= data_in;
        end
        // dqi valid at edge N + CAS_LATENCY after the read
        if (state == READ_WAIT && rd_cnt == RD_W'(1)) rd_word <= sdram_dqi;
        if (state == READ_WAIT && rd_cnt == '0) data_out <= rd_word;
    end

    always_comb begin
        req  = 1'b0;
        cmd  = CMD_NOP;
        addr = '0;
        case (state)
            PRECHARGE: begin
                req = 1'b1;
                cmd = CMD_PRECHARGE;
            end
            ACTIVATE: begin
                req  = 1'b1;
                cmd  = CMD_ACTIVE;
                addr = q_row;
            end
            ISSUE: begin
                req  = 1'b1;
                cmd  = q_rw ? CMD_WRITE : CMD_READ;
                // column sits in a[9:2], a10 low so no auto precharge
                addr = {2'b00, 1'b0, q_col, 2'b00};
            end
            default: ;
        endcase
    end

    assign bank  = q_bank;
    assign wdata = q_data;

endmodule

//--- rtl/bank_row_table.sv
module bank_row_table
    import sdram_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       issue,
    input  sdram_cmd_t                 cmd,
    input  bank_t                      bank,
    input  pin_addr_t                  addr,
    output logic [NUM_BANKS-1:0]       row_open,
    output row_t [NUM_BANKS-1:0]       open_row
);

    // open flags follow every command put on the pins
    always_ff @(posedge clk) begin
        if (rst) begin
            row_open <= '0;
        end else if (issue) begin
            case (cmd)
                CMD_ACTIVE: begin
                    row_open[bank] <= 1'b1;
                end
                CMD_PRECHARGE: begin
                    if (addr[A10_ALL_BANKS]) begin
                        row_open <= '0;
                    end else begin
                        row_open[bank] <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

    // row address only matters while the flag is set
    always_ff @(posedge clk) begin
        if (issue && cmd == CMD_ACTIVE) begin
            open_row[bank] <= addr;
        end
    end

endmodule

//--- rtl/cmd_arbiter.sv
module cmd_arbiter
    import sdram_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       acc_req,
    input  logic       acc_lock,
    input  sdram_cmd_t acc_cmd,
    input  bank_t      acc_bank,
    input  pin_addr_t  acc_addr,
    input  logic       ref_req,
    input  logic       ref_lock,
    input  sdram_cmd_t ref_cmd,
    input  bank_t      ref_bank,
    input  pin_addr_t  ref_addr,
    input  word_t      wdata,
    output logic       acc_grant,
    output logic       ref_grant,
    output logic       bus_free,
    output logic       issue,
    output sdram_cmd_t issue_cmd,
    output bank_t      issue_bank,
    output pin_addr_t  issue_addr,
    output logic       sdram_cke,
    output logic       sdram_cs,
    output logic       sdram_ras,
    output logic       sdram_cas,
    output logic       sdram_we,
    output bank_t      sdram_ba,
    output pin_addr_t  sdram_a,
    output word_t      sdram_dqo
);

    requester_t sel;
    logic       sel_req;
    spacing_t   space_cnt;
    sdram_cmd_t pin_cmd;

    // refresh first, unless the sequencer is between its commands
    assign sel = (ref_lock || (ref_req && !acc_lock)) ? REQ_REFRESH : REQ_ACCESS;

    always_comb begin
        case (sel)
            REQ_REFRESH: begin
                sel_req    = ref_req;
                issue_cmd  = ref_cmd;
                issue_bank = ref_bank;
                issue_addr = ref_addr;
            end
            default: begin
                sel_req    = acc_req;
                issue_cmd  = acc_cmd;
                issue_bank = acc_bank;
                issue_addr = acc_addr;
            end
        endcase
    end

    assign bus_free  = (space_cnt == '0);
    assign issue     = bus_free && sel_req;
    assign acc_grant = issue && (sel == REQ_ACCESS);
    assign ref_grant = issue && (sel == REQ_REFRESH);

    always_ff @(posedge clk) begin
        if (rst) begin
            pin_cmd   <= CMD_NOP;
            sdram_cke <= 1'b0;
            space_cnt <= '0;
        end else begin
            sdram_cke <= 1'b1;
            if (issue) begin
                pin_cmd   <= issue_cmd;
                space_cnt <= cmd_spacing(issue_cmd) - 1'b1;
            end else begin
                pin_cmd <= CMD_NOP;
                if (space_cnt != '0) space_cnt <= space_cnt - 1'b1;
            end
        end
    end

    // address and data pins hold between commands
    always_ff @(posedge clk) begin
        if (issue) begin
            sdram_ba <= issue_bank;
            sdram_a  <= issue_addr;
        end
        if (issue && issue_cmd == CMD_WRITE) sdram_dqo <= wdata;
    end

    assign {sdram_cs, sdram_ras, sdram_cas, sdram_we} = pin_cmd;

endmodule

//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

    // user address is {row, bank, col}
    typedef logic [22:0] user_addr_t;
    typedef logic [31:0] word_t;

    localparam int ROW_LSB  = 10;
    localparam int BANK_LSB = 8;
    localparam int COL_LSB  = 0;

    typedef enum logic {
        REQ_ACCESS,
        REQ_REFRESH
    } requester_t;

    typedef enum logic [2:0] {
        IDLE,
        PRECHARGE,
        ACTIVATE,
        ISSUE,
        READ_WAIT,
        WRITE_WAIT
    } seq_state_t;

    typedef enum logic [1:0] {
        COUNT,
        PRECHARGE_ALL,
        REFRESH
    } ref_state_t;

endpackage

//--- rtl/refresh_scheduler.sv
module refresh_scheduler
    import sdram_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int REFRESH_INTERVAL = 750
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       grant,
    output logic       req,
    output logic       lock,
    output sdram_cmd_t cmd,
    output pin_addr_t  addr
);

    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 2);

    logic [CNT_W-1:0] ref_cnt;
    logic             pending;
    ref_state_t       state;

    always_ff @(posedge clk) begin
        if (rst) begin
            ref_cnt <= '0;
            pending <= 1'b0;
            state   <= COUNT;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
            case (state)
                COUNT: begin
                    if (pending) begin
                        pending <= 1'b0;
                        state   <= PRECHARGE_ALL;
                    end
                end
                PRECHARGE_ALL: if (grant) state <= REFRESH;
                REFRESH:       if (grant) state <= COUNT;
                default:       state <= COUNT;
            endcase
            // interval expiry wins over the clear above
            if (ref_cnt > CNT_W'(REFRESH_INTERVAL)) begin
                ref_cnt <= '0;
                pending <= 1'b1;
            end
        end
    end

    always_comb begin
        req  = 1'b0;
        cmd  = CMD_NOP;
        addr = '0;
        case (state)
            PRECHARGE_ALL: begin
                req                 = 1'b1;
                cmd                 = CMD_PRECHARGE;
                addr[A10_ALL_BANKS] = 1'b1;
            end
            REFRESH: begin
                req = 1'b1;
                cmd = CMD_REFRESH;
            end
            default: ;
        endcase
    end

    // keep the bus from precharge-all through refresh
    assign lock = (state == REFRESH);

endmodule

//--- rtl/sdram_controller.sv
module sdram_controller
    import sdram_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int REFRESH_INTERVAL = 750
) (
    input  logic       clk,
    input  logic       rst,
    input  user_addr_t user_addr,
    input  logic       rw,
    input  word_t      data_in,
    input  logic       in_valid,
    input  word_t      sdram_dqi,
    output word_t      data_out,
    output logic       busy,
    output logic       out_valid,
    output logic       sdram_cke,
    output logic       sdram_cs,
    output logic       sdram_ras,
    output logic       sdram_cas,
    output logic       sdram_we,
    output bank_t      sdram_ba,
    output pin_addr_t  sdram_a,
    output word_t      sdram_dqo
);

    logic                 acc_req;
    logic                 acc_lock;
    logic                 acc_grant;
    sdram_cmd_t           acc_cmd;
    bank_t                acc_bank;
    pin_addr_t            acc_addr;
    word_t                wdata;
    logic                 ref_req;
    logic                 ref_lock;
    logic                 ref_grant;
    sdram_cmd_t           ref_cmd;
    pin_addr_t            ref_addr;
    logic                 bus_free;
    logic                 issue;
    sdram_cmd_t           issue_cmd;
    bank_t                issue_bank;
    pin_addr_t            issue_addr;
    logic [NUM_BANKS-1:0] row_open;
    row_t [NUM_BANKS-1:0] open_row;

    access_sequencer u_seq (
        .clk, .rst, .user_addr, .rw, .data_in, .in_valid,
        .grant(acc_grant), .bus_free, .row_open, .open_row, .sdram_dqi,
        .busy, .data_out, .out_valid,
        .req(acc_req), .lock(acc_lock), .cmd(acc_cmd), .bank(acc_bank),
        .addr(acc_addr), .wdata
    );

    refresh_scheduler #(
        .REFRESH_INTERVAL(REFRESH_INTERVAL)
    ) u_ref (
        .clk, .rst, .grant(ref_grant),
        .req(ref_req), .lock(ref_lock), .cmd(ref_cmd), .addr(ref_addr)
    );

    // refresh always targets bank 0; a10 carries the all-banks select
    cmd_arbiter u_arb (
        .clk, .rst,
        .acc_req, .acc_lock, .acc_cmd, .acc_bank, .acc_addr,
        .ref_req, .ref_lock, .ref_cmd, .ref_bank(bank_t'(0)), .ref_addr,
        .wdata, .acc_grant, .ref_grant, .bus_free,
        .issue, .issue_cmd, .issue_bank, .issue_addr,
        .sdram_cke, .sdram_cs, .sdram_ras, .sdram_cas, .sdram_we,
        .sdram_ba, .sdram_a, .sdram_dqo
    );

    bank_row_table u_table (
        .clk, .rst, .issue, .cmd(issue_cmd), .bank(issue_bank),
        .addr(issue_addr), .row_open, .open_row
    );

endmodule

//--- rtl/sdram_pkg.sv
package sdram_pkg;

    // command code as {cs, ras, cas, we}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001
    } sdram_cmd_t;

    typedef logic [1:0]  bank_t;
    typedef logic [12:0] row_t;
    typedef logic [7:0]  col_t;

    // word on the sdram_a pins
    typedef logic [12:0] pin_addr_t;

    // bus occupancy count, wide enough for the longest command
    typedef logic [2:0]  spacing_t;

    localparam int NUM_BANKS = 4;

    // cycles a command holds the bus, its own cycle included
    localparam int T_ACT       = 3;
    localparam int T_PRE       = 3;
    localparam int T_REF       = 7;
    localparam int CAS_LATENCY = 3;

    // a10 on precharge closes every bank
    localparam int A10_ALL_BANKS = 10;

    function automatic spacing_t cmd_spacing(sdram_cmd_t cmd);
        spacing_t cycles;
        case (cmd)
            CMD_ACTIVE:    cycles = spacing_t'(T_ACT);
            CMD_PRECHARGE: cycles = spacing_t'(T_PRE);
            CMD_REFRESH:   cycles = spacing_t'(T_REF);
            CMD_READ,
            CMD_WRITE:     cycles = spacing_t'(CAS_LATENCY);
            default:       cycles = spacing_t'(1);
        endcase
        return cycles;
    endfunction

endpackage

//--- tests/sdram_controller_properties.sv
module sdram_controller_properties
    import sdram_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int REFRESH_INTERVAL = 750
) (
    input logic       clk,
    input logic       rst,
    input user_addr_t user_addr,
    input logic       in_valid,
    input logic       busy,
    input logic       out_valid,
    input logic       sdram_cke,
    input logic       sdram_cs,
    input logic       sdram_ras,
    input logic       sdram_cas,
    input logic       sdram_we,
    input bank_t      sdram_ba,
    input pin_addr_t  sdram_a
);
    timeunit 1ns;
    timeprecision 100ps;

    sdram_cmd_t pin_cmd;
    logic       was_rst;
    int         gap;
    int         since_ref;
    logic       prev_pre_all;
    logic       bank_open [NUM_BANKS];
    row_t       bank_row [NUM_BANKS];
    row_t       req_row;
    bank_t      req_bank;
    int         fail_count = 0;

    assign pin_cmd = sdram_cmd_t'({sdram_cs, sdram_ras, sdram_cas, sdram_we});

    // bus cycles per command, own cycle included
    function automatic int bus_cycles(sdram_cmd_t c);
        if (c == CMD_ACTIVE) return T_ACT;
        if (c == CMD_PRECHARGE) return T_PRE;
        if (c == CMD_REFRESH) return T_REF;
        return CAS_LATENCY;
    endfunction

    // pin-side view of spacing, banks and refresh history
    always_ff @(posedge clk) begin
        was_rst <= rst;
        if (rst) begin
            gap          <= 0;
            since_ref    <= 0;
            prev_pre_all <= 1'b0;
            for (int b = 0; b < NUM_BANKS; b++) bank_open[b] <= 1'b0;
        end else begin
            since_ref <= (pin_cmd == CMD_REFRESH) ? 0 : since_ref + 1;
            if (pin_cmd != CMD_NOP) begin
                gap          <= bus_cycles(pin_cmd) - 1;
                prev_pre_all <= (pin_cmd == CMD_PRECHARGE) && sdram_a[A10_ALL_BANKS];
            end else if (gap != 0) begin
                gap <= gap - 1;
            end
            if (pin_cmd == CMD_ACTIVE) begin
                bank_open[sdram_ba] <= 1'b1;
                bank_row[sdram_ba]  <= sdram_a;
            end
            if (pin_cmd == CMD_PRECHARGE) begin
                for (int b = 0; b < NUM_BANKS; b++) begin
                    if (sdram_a[A10_ALL_BANKS] || sdram_ba == bank_t'(b)) bank_open[b] <= 1'b0;
                end
            end
        end
        if (in_valid && !busy) begin
            req_row  <= user_addr[ROW_LSB +: $bits(row_t)];
            req_bank <= user_addr[BANK_LSB +: $bits(bank_t)];
        end
    end

    a_reset_state: assert property (@(posedge clk)
        was_rst |-> pin_cmd == CMD_NOP && !busy && !out_valid && !sdram_cke)
        else begin fail_count++; $error("outputs not idle during reset"); end

    a_cke_up: assert property (@(posedge clk) disable iff (rst)
        (was_rst == 1'b0) |-> sdram_cke)
        else begin fail_count++; $error("cke low after reset"); end

    a_spacing: assert property (@(posedge clk) disable iff (rst)
        gap != 0 |-> pin_cmd == CMD_NOP)
        else begin fail_count++; $error("command issued inside spacing window"); end

    a_active_closed: assert property (@(posedge clk) disable iff (rst)
        pin_cmd == CMD_ACTIVE |-> !bank_open[sdram_ba])
        else begin fail_count++; $error("activate to an open bank"); end

    a_access_row: assert property (@(posedge clk) disable iff (rst)
        (pin_cmd == CMD_READ || pin_cmd == CMD_WRITE) |->
            bank_open[sdram_ba] && sdram_ba == req_bank && bank_row[sdram_ba] == req_row)
        else begin fail_count++; $error("read or write to a closed bank or wrong row"); end

    a_refresh_due: assert property (@(posedge clk) disable iff (rst)
        since_ref <= REFRESH_INTERVAL + 40)
        else begin fail_count++; $error("refresh overdue"); end

    a_refresh_pre: assert property (@(posedge clk) disable iff (rst)
        pin_cmd == CMD_REFRESH |-> prev_pre_all)
        else begin fail_count++; $error("refresh without precharge-all before it"); end

endmodule

//--- tests/tb_sdram_controller.sv
module tb_sdram_controller
    import sdram_pkg::*;
    import ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int REFRESH_INTERVAL = 100;
    localparam int NUM_REQ          = 80;
    localparam int CYCLE_LIMIT      = NUM_REQ * 400 + 2000;

    logic       clk = 1'b0;
    logic       rst;
    user_addr_t user_addr;
    logic       rw;
    word_t      data_in;
    logic       in_valid;
    word_t      sdram_dqi = '0;
    word_t      data_out;
    logic       busy;
    logic       out_valid;
    logic       sdram_cke;
    logic       sdram_cs;
    logic       sdram_ras;
    logic       sdram_cas;
    logic       sdram_we;
    bank_t      sdram_ba;
    pin_addr_t  sdram_a;
    word_t      sdram_dqo;

    logic [31:0] lfsr_state = 32'hca96436c;
    int          cycle_count = 0;
    int          data_errors = 0;
    int          other_errors = 0;
    int          prop_errors;
    word_t       mem_model [user_addr_t];
    word_t       expect_mem [user_addr_t];
    word_t       read_queue [$];
    user_addr_t  read_addr_queue [$];
    row_t        pin_row [NUM_BANKS];
    sdram_cmd_t  pin_cmd;
    user_addr_t  pin_word_addr;
    word_t       dqi_word;
    int          dqi_delay = 0;

    always #5 clk = ~clk;

    sdram_controller #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) i_dut (.*);

    bind sdram_controller sdram_controller_properties #(
        .REFRESH_INTERVAL(REFRESH_INTERVAL)
    ) i_props (.*);

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // banks 0..1, rows 0..2, four columns
    function automatic user_addr_t make_addr();
        row_t  r;
        bank_t b;
        col_t  c;
        r = row_t'(rand_bits(2) % 3);
        b = bank_t'(rand_bits(1));
        c = col_t'(rand_bits(2));
        return {r, b, c};
    endfunction

    // memory model seen from the pins
    assign pin_cmd       = sdram_cmd_t'({sdram_cs, sdram_ras, sdram_cas, sdram_we});
    assign pin_word_addr = {pin_row[sdram_ba], sdram_ba, sdram_a[9:2]};

    always @(posedge clk) begin
        // word held on dqi until the next read
        if (dqi_delay != 0) begin
            dqi_delay = dqi_delay - 1;
            if (dqi_delay == 0) sdram_dqi <= dqi_word;
        end
        if (pin_cmd == CMD_ACTIVE) pin_row[sdram_ba] = sdram_a;
        if (pin_cmd == CMD_WRITE) mem_model[pin_word_addr] = sdram_dqo;
        // read seen one edge after the pins, word must be there at edge n + cas latency
        if (pin_cmd == CMD_READ) begin
            dqi_word  = mem_model.exists(pin_word_addr) ? mem_model[pin_word_addr]
                                                        : word_t'(pin_word_addr);
            dqi_delay = CAS_LATENCY - 2;
        end
    end

    always @(posedge clk) begin : scoreboard
        word_t      exp_word;
        user_addr_t exp_addr;
        if (!rst && in_valid && !busy) begin
            if (rw) begin
                expect_mem[user_addr] = data_in;
            end else begin
                read_queue.push_back(expect_mem.exists(user_addr) ? expect_mem[user_addr]
                                                                  : word_t'(user_addr));
                read_addr_queue.push_back(user_addr);
            end
        end
        if (!rst && out_valid) begin
            if (read_queue.size() == 0) begin
                $display("Error: out_valid with no read outstanding");
                other_errors++;
            end else begin
                exp_word = read_queue.pop_front();
                exp_addr = read_addr_queue.pop_front();
                if (data_out !== exp_word) begin
                    $display("[ERROR] read_data addr %h: expected %h, actual %h",
                             exp_addr, exp_word, data_out);
                    data_errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // one request, optionally followed by one sent while busy
    task automatic send_request(input logic drop_extra);
        user_addr_t a;
        logic       is_write;
        word_t      d;
        a        = make_addr();
        is_write = 1'(rand_bits(1));
        d        = rand_bits(32);
        while (busy) @(posedge clk);
        user_addr <= a;
        rw        <= is_write;
        data_in   <= d;
        in_valid  <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        @(posedge clk);
        if (drop_extra) begin
            user_addr <= make_addr();
            rw        <= 1'b1;
            data_in   <= ~d;
            in_valid  <= 1'b1;
            @(posedge clk);
            in_valid <= 1'b0;
        end
        while (busy) @(posedge clk);
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        user_addr = '0;
        rw        = 1'b0;
        data_in   = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_REQ; i++) send_request(rand_bits(2) == 0);
        repeat (20) @(posedge clk);
        if (read_queue.size() != 0) begin
            $display("Error: %0d reads never returned data", read_queue.size());
            other_errors++;
        end
        prop_errors = i_dut.i_props.fail_count;
        $display("data errors: %0d, other errors: %0d, assertion failures: %0d",
                 data_errors, other_errors, prop_errors);
        if (data_errors + other_errors + prop_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/sdram_pkg.sv
rtl/ctrl_pkg.sv
rtl/refresh_scheduler.sv
rtl/bank_row_table.sv
rtl/access_sequencer.sv
rtl/cmd_arbiter.sv
rtl/sdram_controller.sv
tests/sdram_controller_properties.sv
tests/tb_sdram_controller.sv
